//--- hdl/aesOpPkg.sv
// Opcode encoding for the scalar AES instructions
// Byte index type shared by the decode and the datapath

package aesOpPkg;

   ////////////////////
   // Opcodes
   ////////////////////

   // Scalar AES operations from Zkne and Zknd
   // Esi and Dsi are the final-round forms with no MixColumns step
   typedef enum logic [1:0] {
      AesEsi  = 2'd0,
      AesEsmi = 2'd1,
      AesDsi  = 2'd2,
      AesDsmi = 2'd3
   } aesOp_t;

   ////////////////////
   // Byte select
   ////////////////////

   // Index of the rs2 byte that feeds the S-box
   // Also the left rotation of the column, counted in bytes
   typedef logic [1:0] byteSel_t;

endpackage : aesOpPkg

//--- hdl/gfMathPkg.sv
// GF(2^8) arithmetic over the AES field
// Constants for the reduction polynomial and the affine offset

package gfMathPkg;

   // x^8 + x^4 + x^3 + x + 1
   localparam logic [8:0] AesPoly     = 9'h11B;
   // Offset of the S-box affine map
   localparam logic [7:0] AffineConst = 8'h63;

   ////////////////////
   // Field operations
   ////////////////////

   // Multiply by x, reduced modulo the AES polynomial
   function automatic logic [7:0] gfXtime(input logic [7:0] a);
      logic [8:0] shifted;
      shifted = {a, 1'b0};
      if (shifted[8])
         shifted = shifted ^ AesPoly;
      return shifted[7:0];
   endfunction

   // Shift-and-add multiply, one xtime per bit of b
   function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] acc;
      logic [7:0] term;
      acc  = 8'h00;
      term = a;
      for (int i = 0; i < 8; i++) begin
         if (b[i])
            acc = acc ^ term;
         term = gfXtime(term);
      end
      return acc;
   endfunction

   // Inverse as a^254, so an input of zero maps to zero
   // Addition chain over the odd powers 3, 7, 15 ... 127, then one last square
   function automatic logic [7:0] gfInv(input logic [7:0] a);
      logic [7:0] acc;
      acc = a;
      for (int i = 0; i < 6; i++) begin
         // acc goes from a^(2^k - 1) to a^(2^(k+1) - 1)
         acc = gfMul(gfMul(acc, acc), a);
      end
      // a^127 squared gives a^254
      return gfMul(acc, acc);
   endfunction

endpackage : gfMathPkg

//--- hdl/aesEncColumn.sv
// Forward S-box of one byte
// Forward MixColumns column, or the bare substituted byte in the final round

`timescale 1ns/1ps

module aesEncColumn import gfMathPkg::*; (
   input  logic [7:0]  byteIn,
   input  logic        finalRound,
   output logic [31:0] column
);

   logic [7:0] invByte;
   logic [7:0] sboxByte;
   logic [7:0] sbox2;
   logic [7:0] sbox3;

   ////////////////////
   // S-box
   ////////////////////

   // Multiplicative inverse first
   assign invByte = gfInv(byteIn);

   // Affine map, the byte XOR four left rotations of itself, plus the offset
   assign sboxByte = invByte
                   ^ {invByte[6:0], invByte[7]}
                   ^ {invByte[5:0], invByte[7:6]}
                   ^ {invByte[4:0], invByte[7:5]}
                   ^ {invByte[3:0], invByte[7:4]}
                   ^ AffineConst;

   ////////////////////
   // MixColumns
   ////////////////////

   // Coefficients 2 and 3 of the forward matrix
   assign sbox2 = gfXtime(sboxByte);
   assign sbox3 = sbox2 ^ sboxByte;

   // Low to high 2s, s, s, 3s
   // Final round passes the substituted byte only
   always_comb begin
      if (finalRound)
         column = {24'h000000, sboxByte};
      else
         column = {sbox3, sboxByte, sboxByte, sbox2};
   end

endmodule : aesEncColumn

//--- hdl/aesDecColumn.sv
// Inverse S-box of one byte
// Inverse MixColumns column, or the bare byte in the final round

`timescale 1ns/1ps

module aesDecColumn import gfMathPkg::*; (
   input  logic [7:0]  byteIn,
   input  logic        finalRound,
   output logic [31:0] column
);

   logic [7:0] unOffset;
   logic [7:0] preInv;
   logic [7:0] sboxByte;
   logic [7:0] mul09;
   logic [7:0] mul0B;
   logic [7:0] mul0D;
   logic [7:0] mul0E;

   ////////////////////
   // Inverse S-box
   ////////////////////

   // Strip the affine offset before undoing the linear part
   assign unOffset = byteIn ^ AffineConst;

   // Inverse linear map, rotations by 1, 3 and 6
   assign preInv = {unOffset[6:0], unOffset[7]}
                 ^ {unOffset[4:0], unOffset[7:5]}
                 ^ {unOffset[1:0], unOffset[7:2]};

   // Field inverse last, the reverse order of the forward S-box
   assign sboxByte = gfInv(preInv);

   ////////////////////
   // InvMixColumns
   ////////////////////

   // Coefficients of the inverse matrix column
   assign mul09 = gfMul(sboxByte, 8'h09);
   assign mul0B = gfMul(sboxByte, 8'h0B);
   assign mul0D = gfMul(sboxByte, 8'h0D);
   assign mul0E = gfMul(sboxByte, 8'h0E);

   // Low to high 0E, 09, 0D, 0B
   always_comb begin
      if (finalRound)
         column = {24'h000000, sboxByte};
      else
         column = {mul0B, mul0D, mul09, mul0E};
   end

endmodule : aesDecColumn

//--- hdl/aesRoundStep.sv
// Combinational AES round step for one rs2 byte
// Byte select, encrypt or decrypt column, rotate and XOR into rs1

`timescale 1ns/1ps

module aesRoundStep import aesOpPkg::*; #(
   parameter bit ZkndSupported = 1'b1,
   parameter bit ZkneSupported = 1'b1
) (
   input  logic [31:0] rs1,
   input  logic [31:0] rs2,
   input  byteSel_t    bs,
   input  logic        decrypt,
   input  logic        finalRound,
   output logic [31:0] roundResult
);

   logic [4:0]  shamt;
   logic [7:0]  selByte;
   logic [31:0] mixColumn;
   logic [63:0] rotDouble;

   // Byte index to bit offset
   assign shamt   = {bs, 3'b000};
   assign selByte = rs2[shamt +: 8];

   ////////////////////
   // Column select
   ////////////////////

   // Only the supported directions are built
   if (ZkndSupported && ZkneSupported) begin : gBoth
      logic [31:0] encColumn;
      logic [31:0] decColumn;

      aesEncColumn u_aesEncColumn (.byteIn(selByte), .finalRound, .column(encColumn));
      aesDecColumn u_aesDecColumn (.byteIn(selByte), .finalRound, .column(decColumn));

      assign mixColumn = decrypt ? decColumn : encColumn;
   end else if (ZkndSupported) begin : gDecOnly
      // decrypt is always set here, the decode rejects encrypt ops
      aesDecColumn u_aesDecColumn (.byteIn(selByte), .finalRound, .column(mixColumn));
   end else begin : gEncOnly
      aesEncColumn u_aesEncColumn (.byteIn(selByte), .finalRound, .column(mixColumn));
   end

   ////////////////////
   // Rotate and XOR
   ////////////////////

   // Left rotate via a doubled word, upper half holds the result
   assign rotDouble   = {mixColumn, mixColumn} << shamt;
   assign roundResult = rs1 ^ rotDouble[63:32];

endmodule : aesRoundStep

//--- hdl/aesCryptoUnit.sv
// Scalar AES execute unit, opcode decode and support check
// Registered result with one-cycle done and illegal pulses

`timescale 1ns/1ps

module aesCryptoUnit import aesOpPkg::*; #(
   parameter bit ZkndSupported = 1'b1,
   parameter bit ZkneSupported = 1'b1
) (
   input  logic        clk,
   input  logic        rstN,
   input  logic        start,
   input  aesOp_t      op,
   input  byteSel_t    bs,
   input  logic [31:0] rs1,
   input  logic [31:0] rs2,
   output logic [31:0] result,
   output logic        done,
   output logic        illegal
);

   logic        decrypt;
   logic        finalRound;
   logic        supported;
   logic [31:0] roundResult;

   ////////////////////
   // Decode
   ////////////////////

   always_comb begin
      decrypt    = 1'b0;
      finalRound = 1'b0;
      unique case (op)
         AesEsi: begin
            finalRound = 1'b1;
         end
         AesEsmi: begin
            // Middle encrypt round, both levels stay low
            decrypt    = 1'b0;
         end
         AesDsi: begin
            decrypt    = 1'b1;
            finalRound = 1'b1;
         end
         AesDsmi: begin
            decrypt    = 1'b1;
         end
         default: begin
            decrypt    = 1'b0;
         end
      endcase
   end

   // Direction must be present in this build
   assign supported = decrypt ? ZkndSupported : ZkneSupported;

   // Datapath, zero cycles
   aesRoundStep #(
      .ZkndSupported(ZkndSupported),
      .ZkneSupported(ZkneSupported)
   ) u_aesRoundStep (
      .rs1,
      .rs2,
      .bs,
      .decrypt,
      .finalRound,
      .roundResult
   );

   ////////////////////
   // Execute register
   ////////////////////

   // One op per cycle, result held between starts
   always_ff @(posedge clk) begin
      if (!rstN) begin
         result  <= '0;
         done    <= 1'b0;
         illegal <= 1'b0;
      end else begin
         done    <= start && supported;
         illegal <= start && !supported;
         if (start)
            result <= supported ? roundResult : 32'h0000_0000;
      end
   end

endmodule : aesCryptoUnit

//--- verification/aesCryptoChecker.sv
// Reference model of the scalar AES instructions
// Watches the DUT ports, compares result and pulses each cycle, counts errors

`timescale 1ns/1ps

module aesCryptoChecker import aesOpPkg::*; #(
   parameter bit ZkndSupported = 1'b1,
   parameter bit ZkneSupported = 1'b1
) (
   input logic        clk,
   input logic        rstN,
   input logic        start,
   input aesOp_t      op,
   input byteSel_t    bs,
   input logic [31:0] rs1,
   input logic [31:0] rs2,
   input logic [31:0] result,
   input logic        done,
   input logic        illegal
);

   int          errorCount = 0;
   int          checkCount = 0;
   logic        expStart;
   logic        expLegal;
   logic [31:0] modelResult;

   ////////////////////
   // Reference model
   ////////////////////

   // Peasant multiply, reduce by 0x1B whenever bit 7 falls out
   function automatic logic [7:0] fieldMul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] x;
      logic [7:0] y;
      logic [7:0] p;
      x = a;
      y = b;
      p = 8'h00;
      while (y != 8'h00) begin
         if (y[0])
            p = p ^ x;
         x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1B) : {x[6:0], 1'b0};
         y = y >> 1;
      end
      return p;
   endfunction

   // Square and multiply over the exponent 254, zero stays zero
   function automatic logic [7:0] fieldPow254(input logic [7:0] a);
      logic [7:0] acc;
      logic [7:0] base;
      logic [7:0] expBits;
      acc     = 8'h01;
      base    = a;
      expBits = 8'hFE;
      for (int i = 0; i < 8; i++) begin
         if (expBits[i])
            acc = fieldMul(acc, base);
         base = fieldMul(base, base);
      end
      return acc;
   endfunction

   // Bitwise affine map, s_i = b_i ^ b_i+4 ^ b_i+5 ^ b_i+6 ^ b_i+7 ^ c_i
   function automatic logic [7:0] fwdSbox(input logic [7:0] x);
      logic [7:0] b;
      logic [7:0] s;
      b = fieldPow254(x);
      for (int i = 0; i < 8; i++)
         s[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8]
              ^ b[(i + 7) % 8] ^ 8'h63 >> i & 1'b1;
      return s;
   endfunction

   // Inverse affine, b_i = s_i+2 ^ s_i+5 ^ s_i+7 ^ d_i with d = 0x05
   function automatic logic [7:0] invSbox(input logic [7:0] s);
      logic [7:0] b;
      logic [7:0] d;
      d = 8'h05;
      for (int i = 0; i < 8; i++)
         b[i] = s[(i + 2) % 8] ^ s[(i + 5) % 8] ^ s[(i + 7) % 8] ^ d[i];
      return fieldPow254(b);
   endfunction

   function automatic logic [31:0] aesRef(input aesOp_t opIn, input byteSel_t bsIn,
                                          input logic [31:0] rs1In, input logic [31:0] rs2In);
      logic [7:0]  x;
      logic [7:0]  s;
      logic [31:0] col;
      x = rs2In[8 * bsIn +: 8];
      case (opIn)
         AesEsi:  col = {24'h000000, fwdSbox(x)};
         AesEsmi: begin
            s   = fwdSbox(x);
            col = {fieldMul(s, 8'h03), s, s, fieldMul(s, 8'h02)};
         end
         AesDsi:  col = {24'h000000, invSbox(x)};
         default: begin
            s   = invSbox(x);
            col = {fieldMul(s, 8'h0B), fieldMul(s, 8'h0D), fieldMul(s, 8'h09),
                   fieldMul(s, 8'h0E)};
         end
      endcase
      // Rotate left one byte per step of bs
      for (int i = 0; i < 4; i++)
         if (i < bsIn)
            col = {col[23:0], col[31:24]};
      return rs1In ^ col;
   endfunction

   function automatic bit opSupported(input aesOp_t opIn);
      if (opIn == AesDsi || opIn == AesDsmi)
         return ZkndSupported;
      return ZkneSupported;
   endfunction

   ////////////////////
   // Compare
   ////////////////////

   task automatic reportValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      errorCount++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
   endtask

   task automatic reportSummary();
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
   endtask

   // Take the operation at the same edge as the DUT
   always @(posedge clk) begin
      if (!rstN) begin
         expStart    <= 1'b0;
         expLegal    <= 1'b0;
         modelResult <= 32'h0000_0000;
      end else begin
         expStart <= start;
         expLegal <= opSupported(op);
         if (start)
            modelResult <= opSupported(op) ? aesRef(op, bs, rs1, rs2) : 32'h0000_0000;
      end
   end

   // Outputs settle between edges
   always @(negedge clk) begin
      if (rstN) begin
         checkCount++;
         if (done !== (expStart && expLegal))
            reportValue("done", {31'd0, expStart && expLegal}, {31'd0, done});
         if (illegal !== (expStart && !expLegal))
            reportValue("illegal", {31'd0, expStart && !expLegal}, {31'd0, illegal});
         if (result !== modelResult)
            reportValue("result", modelResult, result);
      end
   end

endmodule : aesCryptoChecker

//--- verification/aesCryptoTb.sv
// Testbench top for the scalar AES unit
// Clock, reset, directed and random stimulus, watchdog, checker instance

`timescale 1ns/1ps

module aesCryptoTb import aesOpPkg::*; ();

   localparam int ClkPeriod    = 20;
   localparam int NumRandomOps = 400;
   // Random ops plus a margin for reset and the directed cases
   localparam int TimeoutNs    = NumRandomOps * ClkPeriod + 2000;

   logic        clk;
   logic        rstN;
   logic        start;
   aesOp_t      op;
   byteSel_t    bs;
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic [31:0] result;
   logic        done;
   logic        illegal;

   aesCryptoUnit #(
      .ZkndSupported(1'b1),
      .ZkneSupported(1'b1)
   ) u_aesCryptoUnit (
      .clk, .rstN, .start, .op, .bs, .rs1, .rs2, .result, .done, .illegal
   );

   aesCryptoChecker #(
      .ZkndSupported(1'b1),
      .ZkneSupported(1'b1)
   ) u_aesCryptoChecker (
      .clk, .rstN, .start, .op, .bs, .rs1, .rs2, .result, .done, .illegal
   );

   initial begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   ////////////////////
   // Stimulus
   ////////////////////

   // One start per call, so consecutive calls run back to back
   task automatic issueOp(input aesOp_t opIn, input byteSel_t bsIn,
                          input logic [31:0] rs1In, input logic [31:0] rs2In);
      start <= 1'b1;
      op    <= opIn;
      bs    <= bsIn;
      rs1   <= rs1In;
      rs2   <= rs2In;
      @(posedge clk);
   endtask

   // Operands keep moving, result must still hold
   task automatic idleCycle();
      start <= 1'b0;
      rs1   <= $urandom();
      rs2   <= $urandom();
      @(posedge clk);
   endtask

   initial begin
      int          seedValue;
      logic [31:0] rs2Val;
      seedValue = $urandom(32'ha5e9);
      rstN  = 1'b0;
      start = 1'b0;
      op    = AesEsi;
      bs    = 2'd0;
      rs1   = 32'h0000_0000;
      rs2   = 32'h0000_0000;
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      // Nothing started yet
      repeat (3) idleCycle();
      // Final rounds, 0x00 maps to 0x63 and back at every byte index
      for (int b = 0; b < 4; b++) begin
         issueOp(AesEsi, byteSel_t'(b), 32'h0000_0000, 32'h0000_0000);
         idleCycle();
      end
      for (int b = 0; b < 4; b++) begin
         rs2Val = $urandom();
         rs2Val[8 * b +: 8] = 8'h63;
         issueOp(AesDsi, byteSel_t'(b), $urandom(), rs2Val);
         idleCycle();
      end
      // Middle rounds interleaved on consecutive cycles
      for (int i = 0; i < NumRandomOps / 2; i++) begin
         issueOp(AesEsmi, byteSel_t'($urandom()), $urandom(), $urandom());
         issueOp(AesDsmi, byteSel_t'($urandom()), $urandom(), $urandom());
      end
      repeat (3) idleCycle();
      // Last negedge compare is complete by the next rising edge
      @(posedge clk);
      u_aesCryptoChecker.reportSummary();
      if (u_aesCryptoChecker.errorCount == 0 && u_aesCryptoChecker.checkCount > 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   ////////////////////
   // Watchdog
   ////////////////////

   initial begin
      #(TimeoutNs);
      $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
      u_aesCryptoChecker.reportSummary();
      $display("Simulation FAILED");
      $finish;
   end

endmodule : aesCryptoTb

//--- verilog.f
hdl/aesOpPkg.sv
hdl/gfMathPkg.sv
hdl/aesEncColumn.sv
hdl/aesDecColumn.sv
hdl/aesRoundStep.sv
hdl/aesCryptoUnit.sv
verification/aesCryptoChecker.sv
verification/aesCryptoTb.sv

//--- Bender.yml
package:
  name: aes_crypto_unit

sources:
  - files:
      - hdl/aesOpPkg.sv
      - hdl/gfMathPkg.sv
      - hdl/aesEncColumn.sv
      - hdl/aesDecColumn.sv
      - hdl/aesRoundStep.sv
      - hdl/aesCryptoUnit.sv
  - target: test
    files:
      - verification/aesCryptoChecker.sv
      - verification/aesCryptoTb.sv
